//--- Makefile
# Verilator build and run for the fetch subsystem testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal
TOP       := tb_fetch_subsystem
FILELIST  := all.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)

//--- all.f
hdl/rv32_front_pkg.sv
hdl/axi_lite_pkg.sv
hdl/fetch_unit.sv
hdl/fetch_queue.sv
hdl/execute_unit.sv
hdl/fetch_subsystem_top.sv
tb/tb_axi_imem.sv
tb/tb_fetch_subsystem.sv

//--- hdl/axi_lite_pkg.sv
//********************************************************************
// AXI4-Lite read channel types
// AR and R payloads and the response code
//********************************************************************

package axi_lite_pkg;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_t;

    // Read address payload, valid travels beside it
    typedef struct packed {
        logic [31:0] araddr;
        logic [2:0]  arprot;
    } axi_ar_t;

    // Read data payload
    typedef struct packed {
        logic [31:0] rdata;
        axi_resp_t   rresp;
    } axi_r_t;

    // Unprivileged, secure, instruction access
    localparam logic [2:0] ARPROT_INSTR = 3'b100;

endpackage

//--- hdl/execute_unit.sv
//********************************************************************
// Execute unit
// Finds JAL at the queue head, computes its target, redirects
// fetch and hands every instruction to the retire port
//********************************************************************

module execute_unit (
    input  logic                          CLK,
    input  logic                          nRST,
    input  rv32_front_pkg::fetch_packet_t head,
    input  logic                          not_empty,
    output logic                          pop,
    output rv32_front_pkg::redirect_t     redirect,
    output rv32_front_pkg::retire_t       retire,
    output logic                          retire_valid,
    input  logic                          retire_ready
);
    import rv32_front_pkg::*;

    opcode_t      opcode;
    logic         is_jal;
    word_t        j_imm;
    word_t        target;
    logic         misaligned;
    retire_kind_t kind;
    retire_t      retire_q;
    logic         retire_valid_q;

    assign opcode = opcode_t'(head.instr[6:0]);
    assign is_jal = (opcode == OP_JAL);

    // J-type immediate, bit 0 always zero
    assign j_imm = {{11{head.instr[31]}}, head.instr[31], head.instr[19:12],
                    head.instr[20], head.instr[30:21], 1'b0};
    assign target     = head.pc + j_imm;
    assign misaligned = (target[1:0] != 2'b00);

    // Bus fault takes priority over anything decoded from the word
    always_comb begin
        if (head.bus_fault) begin
            kind = RK_BUS_FAULT;
        end else if (is_jal && misaligned) begin
            kind = RK_MISALIGNED;
        end else if (is_jal) begin
            kind = RK_JUMP;
        end else begin
            kind = RK_NORMAL;
        end
    end

    // Pop when the retire slot is empty or draining this cycle
    assign pop = not_empty && (!retire_valid_q || retire_ready);

    assign redirect.valid  = pop && (kind == RK_JUMP);
    assign redirect.target = target;

    assign retire       = retire_q;
    assign retire_valid = retire_valid_q;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            retire_valid_q <= 1'b0;
        end else if (pop) begin
            retire_valid_q <= 1'b1;
        end else if (retire_ready) begin
            retire_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (pop) begin
            retire_q.pc    <= head.pc;
            retire_q.instr <= head.instr;
            retire_q.kind  <= kind;
        end
    end

endmodule

//--- hdl/fetch_queue.sv
//********************************************************************
// Fetch queue
// In-order circular buffer of fetch packets between fetch and
// execute, emptied in one cycle by a flush
//********************************************************************

module fetch_queue (
    input  logic                          CLK,
    input  logic                          nRST,
    input  logic                          push,
    input  rv32_front_pkg::fetch_packet_t packet,
    input  logic                          flush,
    input  logic                          pop,
    output rv32_front_pkg::fetch_packet_t head,
    output logic                          not_empty,
    output logic [2:0]                    count
);
    import rv32_front_pkg::*;

    fetch_packet_t     mem [QUEUE_DEPTH];
    logic [QPTR_W-1:0] wr_ptr;
    logic [QPTR_W-1:0] rd_ptr;
    logic              do_pop;

    assign not_empty = (count != 3'd0);
    assign head      = mem[rd_ptr];
    assign do_pop    = pop && not_empty;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            // Flush wins over a push in the same cycle
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, do_pop})
                2'b10:   count <= count + 3'd1;
                2'b01:   count <= count - 3'd1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (push) begin
            mem[wr_ptr] <= packet;
        end
    end

endmodule

//--- hdl/fetch_subsystem_top.sv
//********************************************************************
// Fetch subsystem top
// Fetch, queue and execute, with the AXI read port and the retire
// port brought out
//********************************************************************

module fetch_subsystem_top (
    input  logic                    CLK,
    input  logic                    nRST,
    output axi_lite_pkg::axi_ar_t   ar,
    output logic                    arvalid,
    input  logic                    arready,
    input  axi_lite_pkg::axi_r_t    r,
    input  logic                    rvalid,
    output logic                    rready,
    output rv32_front_pkg::retire_t retire,
    output logic                    retire_valid,
    input  logic                    retire_ready
);
    import rv32_front_pkg::*;

    logic          push;
    fetch_packet_t packet;
    logic [2:0]    queue_count;
    fetch_packet_t head;
    logic          not_empty;
    logic          pop;
    redirect_t     redirect;

    fetch_unit u_fetch (
        .CLK         (CLK),
        .nRST        (nRST),
        .ar          (ar),
        .arvalid     (arvalid),
        .arready     (arready),
        .r           (r),
        .rvalid      (rvalid),
        .rready      (rready),
        .push        (push),
        .packet      (packet),
        .queue_count (queue_count),
        .redirect    (redirect)
    );

    // Redirect doubles as the queue flush
    fetch_queue u_queue (
        .CLK       (CLK),
        .nRST      (nRST),
        .push      (push),
        .packet    (packet),
        .flush     (redirect.valid),
        .pop       (pop),
        .head      (head),
        .not_empty (not_empty),
        .count     (queue_count)
    );

    execute_unit u_execute (
        .CLK          (CLK),
        .nRST         (nRST),
        .head         (head),
        .not_empty    (not_empty),
        .pop          (pop),
        .redirect     (redirect),
        .retire       (retire),
        .retire_valid (retire_valid),
        .retire_ready (retire_ready)
    );

endmodule

//--- hdl/fetch_unit.sv
//********************************************************************
// Fetch unit
// Holds the PC, issues instruction reads over AXI4-Lite under a
// credit limit and tags each read with an epoch so that responses
// from before a redirect are dropped
//********************************************************************

module fetch_unit (
    input  logic                          CLK,
    input  logic                          nRST,
    output axi_lite_pkg::axi_ar_t         ar,
    output logic                          arvalid,
    input  logic                          arready,
    input  axi_lite_pkg::axi_r_t          r,
    input  logic                          rvalid,
    output logic                          rready,
    output logic                          push,
    output rv32_front_pkg::fetch_packet_t packet,
    input  logic [2:0]                    queue_count,
    input  rv32_front_pkg::redirect_t     redirect
);
    import rv32_front_pkg::*;
    import axi_lite_pkg::*;

    word_t       pc;
    logic        epoch;
    logic        arvalid_q;
    word_t       araddr_q;
    logic [1:0]  inflight;
    logic [3:0]  credit_used;
    logic        slot_free;
    logic        credit_ok;
    logic        do_load;
    logic        resp_fire;

    // In-flight record, one slot per outstanding read
    word_t       rec_pc    [MAX_OUTSTANDING];
    logic        rec_epoch [MAX_OUTSTANDING];
    logic        rec_wr;
    logic        rec_rd;

    // AR slot counts as in flight from the moment it is loaded
    assign credit_used = 4'(inflight) + 4'(queue_count);
    assign credit_ok   = (credit_used < 4'(QUEUE_DEPTH))
                       && (inflight < 2'(MAX_OUTSTANDING));
    assign slot_free   = !arvalid_q || arready;
    // No load while the PC is being redirected
    assign do_load     = slot_free && credit_ok && !redirect.valid;
    assign resp_fire   = rvalid && rready;

    assign arvalid   = arvalid_q;
    assign ar.araddr = araddr_q;
    assign ar.arprot = ARPROT_INSTR;
    assign rready    = 1'b1;

    // Stale epochs are dropped here
    assign push             = resp_fire && (rec_epoch[rec_rd] == epoch);
    assign packet.pc        = rec_pc[rec_rd];
    assign packet.instr     = r.rdata;
    assign packet.bus_fault = (r.rresp != OKAY);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            pc        <= RESET_PC;
            epoch     <= 1'b0;
            arvalid_q <= 1'b0;
            rec_wr    <= 1'b0;
            rec_rd    <= 1'b0;
        end else begin
            if (redirect.valid) begin
                pc    <= redirect.target;
                epoch <= ~epoch;
            end else if (do_load) begin
                pc <= pc + 32'd4;
            end

            if (do_load) begin
                arvalid_q <= 1'b1;
                rec_wr    <= ~rec_wr;
            end else if (arready) begin
                arvalid_q <= 1'b0;
            end

            if (resp_fire) begin
                rec_rd <= ~rec_rd;
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            inflight <= '0;
        end else begin
            case ({do_load, resp_fire})
                2'b10:   inflight <= inflight + 2'd1;
                2'b01:   inflight <= inflight - 2'd1;
                default: inflight <= inflight;
            endcase
        end
    end

    // Address and record payload
    always_ff @(posedge CLK) begin
        if (do_load) begin
            araddr_q          <= pc;
            rec_pc[rec_wr]    <= pc;
            rec_epoch[rec_wr] <= epoch;
        end
    end

endmodule

//--- hdl/rv32_front_pkg.sv
//********************************************************************
// RV32 front end types
// Instruction words, major opcodes, fetch packets, retire records
// and the redirect bundle shared by fetch, queue and execute
//********************************************************************

package rv32_front_pkg;

    typedef logic [31:0] word_t;

    // RV32I major opcodes, bits 6:0 of the instruction
    typedef enum logic [6:0] {
        OP_LOAD     = 7'b0000011,
        OP_MISC_MEM = 7'b0001111,
        OP_IMM      = 7'b0010011,
        OP_AUIPC    = 7'b0010111,
        OP_STORE    = 7'b0100011,
        OP_REG      = 7'b0110011,
        OP_LUI      = 7'b0110111,
        OP_BRANCH   = 7'b1100011,
        OP_JALR     = 7'b1100111,
        OP_JAL      = 7'b1101111,
        OP_SYSTEM   = 7'b1110011
    } opcode_t;

    typedef enum logic [1:0] {
        RK_NORMAL     = 2'd0,
        RK_JUMP       = 2'd1,
        RK_BUS_FAULT  = 2'd2,
        RK_MISALIGNED = 2'd3
    } retire_kind_t;

    typedef struct packed {
        word_t pc;
        word_t instr;
        logic  bus_fault;
    } fetch_packet_t;

    typedef struct packed {
        word_t        pc;
        word_t        instr;
        retire_kind_t kind;
    } retire_t;

    typedef struct packed {
        logic  valid;
        word_t target;
    } redirect_t;

    localparam word_t RESET_PC        = 32'h0000_0000;
    localparam int    QUEUE_DEPTH     = 4;
    localparam int    QPTR_W          = $clog2(QUEUE_DEPTH);
    localparam int    MAX_OUTSTANDING = 2;

endpackage

//--- tb/tb_axi_imem.sv
//********************************************************************
// AXI4-Lite instruction memory model
// 256-word read-only store with up to two pending reads, stalls
// driven from outside and SLVERR on a fixed set of indices
//********************************************************************

module tb_axi_imem (
    input  logic                  CLK,
    input  logic                  nRST,
    input  axi_lite_pkg::axi_ar_t ar,
    input  logic                  arvalid,
    output logic                  arready,
    output axi_lite_pkg::axi_r_t  r,
    output logic                  rvalid,
    input  logic                  rready,
    input  logic                  hold_ar,
    input  logic                  hold_r
);
    import rv32_front_pkg::*;
    import axi_lite_pkg::*;

    // Program store, filled by the testbench at time 0
    word_t      mem [256];

    logic [7:0] pend_idx [2];
    logic       pend_wr;
    logic       pend_rd;
    logic [1:0] pend_cnt;
    logic [1:0] avail;
    logic       ar_fire;
    logic       r_fire;

    // Index 13 and every 29th index after it
    function automatic logic slverr_index(input logic [7:0] idx);
        return (idx >= 8'd13) && (((int'(idx) - 13) % 29) == 0);
    endfunction

    assign arready = (pend_cnt < 2'd2) && !hold_ar;
    assign ar_fire = arvalid && arready;
    assign r_fire  = rvalid && rready;
    assign avail   = pend_cnt - {1'b0, r_fire};

    assign r.rdata = mem[pend_idx[pend_rd]];
    assign r.rresp = slverr_index(pend_idx[pend_rd]) ? SLVERR : OKAY;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            pend_wr  <= 1'b0;
            pend_rd  <= 1'b0;
            pend_cnt <= 2'd0;
            rvalid   <= 1'b0;
        end else begin
            if (ar_fire) begin
                pend_idx[pend_wr] <= ar.araddr[9:2];
                pend_wr           <= ~pend_wr;
            end
            if (r_fire) begin
                pend_rd <= ~pend_rd;
            end
            case ({ar_fire, r_fire})
                2'b10:   pend_cnt <= pend_cnt + 2'd1;
                2'b01:   pend_cnt <= pend_cnt - 2'd1;
                default: pend_cnt <= pend_cnt;
            endcase
            // Valid stays up until the response is taken
            if (r_fire || !rvalid) begin
                rvalid <= (avail != 2'd0) && !hold_r;
            end
        end
    end

endmodule

//--- tb/tb_fetch_subsystem.sv
//********************************************************************
// Fetch subsystem testbench
// Random program in the memory model, random stalls and retire
// back-pressure, every retire checked against a reference model
//********************************************************************

module tb_fetch_subsystem;
    import rv32_front_pkg::*;
    import axi_lite_pkg::*;

    localparam int          CLK_PERIOD        = 20;
    localparam int          DRIVE_DELAY       = 2;
    localparam int          RESET_CYCLES      = 5;
    localparam int          RETIRE_TARGET     = 2000;
    localparam int          CYCLES_PER_RETIRE = 40;
    localparam int          MEM_WORDS         = 256;
    localparam logic [31:0] LFSR_SEED         = 32'h5ab5_9982;

    // Test ids
    localparam int T_FIRST      = 0;
    localparam int T_STRAIGHT   = 1;
    localparam int T_JUMP       = 2;
    localparam int T_MISALIGNED = 3;
    localparam int T_FAULT      = 4;
    localparam int T_SEQUENCE   = 5;
    localparam int T_AXI_PORT   = 6;
    localparam int NUM_TESTS    = 7;

    logic        CLK;
    logic        nRST;
    axi_ar_t     ar;
    logic        arvalid;
    logic        arready;
    axi_r_t      r;
    logic        rvalid;
    logic        rready;
    retire_t     retire;
    logic        retire_valid;
    logic        retire_ready;
    logic        hold_ar;
    logic        hold_r;

    logic [31:0] lfsr_state;
    logic        gen_is_jal [MEM_WORDS];
    word_t       gen_imm [MEM_WORDS];
    word_t       model_pc;
    int          retired;
    int          stall_left;
    int          total_checks;
    int          total_errors;
    int          test_checks [NUM_TESTS];
    int          test_errors [NUM_TESTS];
    string       test_names [NUM_TESTS];
    axi_ar_t     ar_held;
    logic        ar_waiting;

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    fetch_subsystem_top dut (
        .CLK          (CLK),
        .nRST         (nRST),
        .ar           (ar),
        .arvalid      (arvalid),
        .arready      (arready),
        .r            (r),
        .rvalid       (rvalid),
        .rready       (rready),
        .retire       (retire),
        .retire_valid (retire_valid),
        .retire_ready (retire_ready)
    );

    tb_axi_imem imem (
        .CLK     (CLK),
        .nRST    (nRST),
        .ar      (ar),
        .arvalid (arvalid),
        .arready (arready),
        .r       (r),
        .rvalid  (rvalid),
        .rready  (rready),
        .hold_ar (hold_ar),
        .hold_r  (hold_r)
    );

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v          = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic fault_index(input logic [7:0] idx);
        return (idx >= 8'd13) && (((int'(idx) - 13) % 29) == 0);
    endfunction

    function automatic word_t encode_jal(input word_t imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    endfunction

    function automatic opcode_t other_opcode(input logic [3:0] sel);
        case (sel)
            4'd0:    return OP_LOAD;
            4'd1:    return OP_MISC_MEM;
            4'd2:    return OP_AUIPC;
            4'd3:    return OP_STORE;
            4'd4:    return OP_REG;
            4'd5:    return OP_LUI;
            4'd6:    return OP_BRANCH;
            4'd7:    return OP_JALR;
            4'd8:    return OP_SYSTEM;
            default: return OP_IMM;
        endcase
    endfunction

    // Walks the program built so far from start, true once it gets past stop
    function automatic logic escapes(input int start, input int stop);
        int idx;
        idx = start;
        if (idx < 0) begin
            return 1'b0;
        end
        for (int n = 0; n < MEM_WORDS; n++) begin
            if (idx >= stop) begin
                return (idx > stop);
            end
            if (gen_is_jal[idx] && gen_imm[idx][1] == 1'b0 && !fault_index(8'(idx))) begin
                idx = idx + int'($signed(gen_imm[idx])) / 4;
            end else begin
                idx++;
            end
        end
        return 1'b0;
    endfunction

    // About one word in four is a JAL
    task automatic fill_program();
        logic [31:0] bits;
        logic [31:0] upper;
        word_t       imm;
        for (int i = 0; i < MEM_WORDS; i++) begin
            bits = rand_bits(2);
            if (bits[1:0] == 2'd0) begin
                bits = rand_bits(6);
                imm  = {{25{bits[5]}}, bits[5:0], 1'b0};
                // Aligned jumps go back only where the code they land on runs past them
                if (imm[1] == 1'b0 && !escapes(i + int'($signed(imm)) / 4, i)) begin
                    imm = -imm;
                    if (imm == 32'd0) begin
                        imm = 32'd4;
                    end
                end
                bits          = rand_bits(5);
                gen_is_jal[i] = 1'b1;
                gen_imm[i]    = imm;
                imem.mem[i]   = encode_jal(imm, bits[4:0]);
            end else begin
                upper         = rand_bits(25);
                bits          = rand_bits(4);
                gen_is_jal[i] = 1'b0;
                gen_imm[i]    = 32'd0;
                imem.mem[i]   = {upper[24:0], other_opcode(bits[3:0])};
            end
        end
    endtask

    task automatic check_retire(input int tid, input retire_t exp, input retire_t act);
        test_checks[tid]++;
        test_checks[T_SEQUENCE]++;
        total_checks++;
        if (act !== exp) begin
            test_errors[tid]++;
            test_errors[T_SEQUENCE]++;
            total_errors++;
            $display("Fail %s: expected pc %h instr %h kind %s, actual pc %h instr %h kind %s",
                     test_names[tid], exp.pc, exp.instr, exp.kind.name(),
                     act.pc, act.instr, act.kind.name());
        end
    endtask

    task automatic check_kind(input int tid, input retire_kind_t exp, input retire_kind_t act);
        test_checks[tid]++;
        total_checks++;
        if (act !== exp) begin
            test_errors[tid]++;
            total_errors++;
            $display("Fail %s: expected kind %s, actual kind %s",
                     test_names[tid], exp.name(), act.name());
        end
    endtask

    task automatic check_ar(input int tid, input axi_ar_t exp, input axi_ar_t act);
        test_checks[tid]++;
        total_checks++;
        if (act !== exp) begin
            test_errors[tid]++;
            total_errors++;
            $display("Fail %s: expected araddr %h arprot %b, actual araddr %h arprot %b",
                     test_names[tid], exp.araddr, exp.arprot, act.araddr, act.arprot);
        end
    endtask

    // A waiting read address holds valid and payload until accepted
    task automatic check_axi_port();
        test_checks[T_AXI_PORT]++;
        total_checks++;
        if (rready !== 1'b1) begin
            test_errors[T_AXI_PORT]++;
            total_errors++;
            $display("%s: rready is not high, read data cannot be accepted",
                     test_names[T_AXI_PORT]);
        end
        if (ar_waiting) begin
            if (arvalid !== 1'b1) begin
                test_errors[T_AXI_PORT]++;
                total_errors++;
                $display("%s: arvalid dropped before the address was accepted",
                         test_names[T_AXI_PORT]);
            end else begin
                check_ar(T_AXI_PORT, ar_held, ar);
            end
        end
        ar_waiting = (arvalid === 1'b1) && (arready !== 1'b1);
        ar_held    = ar;
    endtask

    // Reference model step for one accepted retire
    task automatic check_next_retire();
        logic [7:0] idx;
        word_t      target;
        retire_t    exp;
        int         tid;
        idx       = model_pc[9:2];
        target    = model_pc + gen_imm[idx];
        exp.pc    = model_pc;
        exp.instr = imem.mem[idx];
        if (fault_index(idx)) begin
            exp.kind = RK_BUS_FAULT;
            tid      = T_FAULT;
        end else if (gen_is_jal[idx] && target[1:0] != 2'b00) begin
            exp.kind = RK_MISALIGNED;
            tid      = T_MISALIGNED;
        end else if (gen_is_jal[idx]) begin
            exp.kind = RK_JUMP;
            tid      = T_JUMP;
        end else begin
            exp.kind = RK_NORMAL;
            tid      = T_STRAIGHT;
        end
        if (retired == 0) begin
            tid = T_FIRST;
        end
        check_retire(tid, exp, retire);
        check_kind(tid, exp.kind, retire.kind);
        model_pc = (exp.kind == RK_JUMP) ? target : model_pc + 32'd4;
        retired++;
    endtask

    // Retire back-pressure with occasional long stalls to fill the queue
    task automatic drive_random_inputs();
        logic [31:0] bits;
        bits = rand_bits(5);
        if (stall_left > 0) begin
            stall_left--;
            retire_ready = 1'b0;
        end else if (bits[4:0] == 5'd0) begin
            stall_left   = 10;
            retire_ready = 1'b0;
        end else begin
            retire_ready = (bits[1:0] != 2'd0);
        end
        bits    = rand_bits(2);
        hold_ar = (bits[1:0] == 2'd0);
        bits    = rand_bits(2);
        hold_r  = (bits[1:0] < 2'd2);
    endtask

    task automatic report_test(input int tid);
        $display("test %-15s checks %0d errors %0d",
                 test_names[tid], test_checks[tid], test_errors[tid]);
    endtask

    initial begin
        CLK          = 1'b0;
        nRST         = 1'b0;
        retire_ready = 1'b0;
        hold_ar      = 1'b0;
        hold_r       = 1'b0;
        lfsr_state   = LFSR_SEED;
        model_pc     = RESET_PC;
        retired      = 0;
        stall_left   = 0;
        total_checks = 0;
        total_errors = 0;
        ar_waiting   = 1'b0;
        test_names[T_FIRST]      = "first_retire";
        test_names[T_STRAIGHT]   = "straight_line";
        test_names[T_JUMP]       = "jal_taken";
        test_names[T_MISALIGNED] = "jal_misaligned";
        test_names[T_FAULT]      = "bus_fault";
        test_names[T_SEQUENCE]   = "full_sequence";
        test_names[T_AXI_PORT]   = "axi_read_port";
        for (int t = 0; t < NUM_TESTS; t++) begin
            test_checks[t] = 0;
            test_errors[t] = 0;
        end
        fill_program();

        repeat (RESET_CYCLES) @(posedge CLK);
        #DRIVE_DELAY;
        nRST = 1'b1;

        while (retired < RETIRE_TARGET) begin
            drive_random_inputs();
            // Handshake is stable by the falling edge
            @(negedge CLK);
            check_axi_port();
            if (retire_valid && retire_ready) begin
                check_next_retire();
                if (retired == 1) begin
                    report_test(T_FIRST);
                end
            end
            @(posedge CLK);
            #DRIVE_DELAY;
        end

        for (int t = T_STRAIGHT; t < NUM_TESTS; t++) begin
            report_test(t);
            if (test_checks[t] == 0) begin
                $display("test %s was never exercised by the random program", test_names[t]);
                total_errors++;
            end
        end
        $display("tests %0d, retired %0d, checks %0d, errors %0d",
                 NUM_TESTS, retired, total_checks, total_errors);
        if (total_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog, sized from the retire count
    initial begin
        #(RETIRE_TARGET * CYCLES_PER_RETIRE * CLK_PERIOD);
        $display("Watchdog expired after %0d of %0d retires, the pipeline stopped retiring",
                 retired, RETIRE_TARGET);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule
